//--- Bender.yml
package:
  name: npu_sys

sources:
  - files:
      - src/npu_pkg.sv
      - src/npu_buffer.sv
      - src/buffer_port_mux.sv
      - src/dma_read_engine.sv
      - src/npu_apb_regs.sv
      - src/npu_sys.sv
  - target: test
    files:
      - bench/npu_sys_chk.sv
      - bench/tb_npu_sys.sv

//--- bench/npu_sys_chk.sv
/*
  Memory channel and interrupt assertions, bound into npu_sys
*/
`timescale 1ns/100ps
`default_nettype none

module npu_sys_chk #(
  parameter int MAX_OUTSTANDING = 4
) (
  input wire                 xclk,
  input wire                 i_reset,
  input wire                 i_req_valid,
  input wire npu_pkg::addr_t i_req_addr,
  input wire                 i_req_ready,
  input wire                 i_rsp_valid,
  input wire                 i_rsp_ready,
  input wire                 i_busy,
  input wire                 i_done,
  input wire                 i_interrupt
);

  logic [7:0]  out_cnt;       // Requests still owed a response
  int unsigned fail_cnt = 0;

  always_ff @(posedge xclk) begin
    if (i_reset)
      out_cnt <= '0;
    else
      out_cnt <= out_cnt + 8'(i_req_valid && i_req_ready) - 8'(i_rsp_valid && i_rsp_ready);
  end

  req_hold: assert property (@(posedge xclk) disable iff (i_reset)
    i_req_valid && !i_req_ready |=> i_req_valid && $stable(i_req_addr))
  else begin
    $error("Stalled request dropped valid or changed its address");
    fail_cnt++;
  end

  req_idle: assert property (@(posedge xclk) disable iff (i_reset)
    !i_busy |-> !i_req_valid)
  else begin
    $error("Request issued while the DMA is idle");
    fail_cnt++;
  end

  out_limit: assert property (@(posedge xclk) disable iff (i_reset)
    out_cnt <= 8'(MAX_OUTSTANDING))
  else begin
    $error("More than %0d requests outstanding", MAX_OUTSTANDING);
    fail_cnt++;
  end

  // Interrupt only rises after a done pulse
  irq_done: assert property (@(posedge xclk) disable iff (i_reset)
    $rose(i_interrupt) |-> $past(i_done))
  else begin
    $error("Interrupt raised without a finished transfer");
    fail_cnt++;
  end

endmodule

bind npu_sys npu_sys_chk #(
  .MAX_OUTSTANDING (MAX_OUTSTANDING)
) u_chk (
  .xclk        (xclk),
  .i_reset     (i_reset),
  .i_req_valid (o_mrd_req_valid),
  .i_req_addr  (o_mrd_req_addr),
  .i_req_ready (i_mrd_req_ready),
  .i_rsp_valid (i_mrd_rsp_valid),
  .i_rsp_ready (o_mrd_rsp_ready),
  .i_busy      (busy),
  .i_done      (done),
  .i_interrupt (o_interrupt)
);

`default_nettype wire

//--- bench/tb_npu_sys.sv
/*
  Testbench for the NPU data-loading subsystem
  APB host, external memory model with stalls, table of DMA transfers
*/
`timescale 1ns/100ps
`default_nettype none

module tb_npu_sys;

  localparam int          N_ROWS = 5;
  localparam logic [31:0] SEED   = 32'hf917_0b2a;

  logic                        xclk = 1'b0;
  logic                        i_reset;
  logic [npu_pkg::PADDR_W-1:0] i_paddr;
  logic                        i_psel;
  logic                        i_penable;
  logic                        i_pwrite;
  npu_pkg::word_t              i_pwdata;
  npu_pkg::word_t              o_prdata;
  logic                        o_mrd_req_valid;
  npu_pkg::addr_t              o_mrd_req_addr;
  logic                        i_mrd_req_ready = 1'b0;
  logic                        i_mrd_rsp_valid = 1'b0;
  npu_pkg::word_t              i_mrd_rsp_data  = '0;
  logic                        o_mrd_rsp_ready;
  logic                        o_interrupt;

  // WB rows have bit 12 set in the destination
  npu_pkg::addr_t row_src   [N_ROWS] = '{32'h0000_1000, 32'h0002_0040, 32'h0003_0100,
                                         32'h0004_0000, 32'h0000_5000};
  npu_pkg::addr_t row_dst   [N_ROWS] = '{32'h0000_0000, 32'h0000_1000, 32'h0000_0040,
                                         32'h0000_1100, 32'h0000_0020};
  npu_pkg::addr_t row_lines [N_ROWS] = '{32'd16, 32'd24, 32'd40, 32'd48, 32'd0};
  logic           row_stall [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};

  integer         seed     = SEED;
  logic           stall_en = 1'b0;
  int unsigned    req_seen = 0;   // Requests accepted by the memory
  npu_pkg::word_t pending [$];    // Responses owed in request order

  npu_sys #(
    .IOB_DEPTH       (256),
    .WB_DEPTH        (512),
    .MAX_OUTSTANDING (4)
  ) npu_sys_i (
    .xclk            (xclk),
    .i_reset         (i_reset),
    .i_paddr         (i_paddr),
    .i_psel          (i_psel),
    .i_penable       (i_penable),
    .i_pwrite        (i_pwrite),
    .i_pwdata        (i_pwdata),
    .o_prdata        (o_prdata),
    .o_mrd_req_valid (o_mrd_req_valid),
    .o_mrd_req_addr  (o_mrd_req_addr),
    .i_mrd_req_ready (i_mrd_req_ready),
    .i_mrd_rsp_valid (i_mrd_rsp_valid),
    .i_mrd_rsp_data  (i_mrd_rsp_data),
    .o_mrd_rsp_ready (o_mrd_rsp_ready),
    .o_interrupt     (o_interrupt)
  );

  always #4 xclk = ~xclk;

  // Memory word mixes every address bit with the seed
  function automatic npu_pkg::word_t model_word(npu_pkg::addr_t a);
    return (a ^ SEED) * 32'h0001_0193 + {a[7:0], a[31:8]};
  endfunction

  // External memory with in-order responses and random idle cycles when stalling
  always @(posedge xclk) begin
    if (i_reset) begin
      i_mrd_req_ready <= 1'b0;
      i_mrd_rsp_valid <= 1'b0;
      pending.delete();
    end else begin
      if (o_mrd_req_valid && i_mrd_req_ready) begin
        pending.push_back(model_word(o_mrd_req_addr));
        req_seen++;
      end
      if (i_mrd_rsp_valid && o_mrd_rsp_ready)
        void'(pending.pop_front());
      i_mrd_req_ready <= !stall_en || ($random(seed) % 3 != 0);
      if (pending.size() > 0 && (!stall_en || ($random(seed) % 3 != 0))) begin
        i_mrd_rsp_valid <= 1'b1;
        i_mrd_rsp_data  <= pending[0];
      end else begin
        i_mrd_rsp_valid <= 1'b0;
      end
    end
  end

  // Stop at the first failed bound assertion
  always @(negedge xclk) begin
    if (npu_sys_i.u_chk.fail_cnt != 0) begin
      $display("A bound assertion failed at %0t ns", $time);
      $display("TEST FAILED");
      $fatal(1, "Assertion failure");
    end
  end

  task automatic check_word(input npu_pkg::word_t got, input npu_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic apb_write(input logic [npu_pkg::PADDR_W-1:0] addr,
                           input npu_pkg::word_t data);
    @(posedge xclk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= 1'b1;
    i_paddr   <= addr;
    i_pwdata  <= data;
    @(posedge xclk);
    i_penable <= 1'b1;
    @(posedge xclk);  // Access edge
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
    i_pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [npu_pkg::PADDR_W-1:0] addr,
                          output npu_pkg::word_t data);
    @(posedge xclk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= 1'b0;
    i_paddr   <= addr;
    @(posedge xclk);
    i_penable <= 1'b1;
    @(negedge xclk);
    data = o_prdata;  // Mid access phase
    @(posedge xclk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  // Window reads of every word a row loaded
  task automatic verify_row(input int r);
    npu_pkg::word_t rd;
    for (int i = 0; i < int'(row_lines[r]); i++) begin
      apb_write(npu_pkg::REG_WIN, row_dst[r] + i);
      apb_read(npu_pkg::REG_WDATA, rd);
      check_word(rd, model_word(row_src[r] + 4 * i), $sformatf("row %0d word %0d", r, i));
    end
  endtask

  task automatic run_row(input int r);
    npu_pkg::word_t rd;
    int unsigned    req_before;
    stall_en <= row_stall[r];
    apb_write(npu_pkg::REG_SRC, row_src[r]);
    apb_write(npu_pkg::REG_DST, row_dst[r]);
    apb_write(npu_pkg::REG_LINES, row_lines[r]);
    apb_read(npu_pkg::REG_SRC, rd);
    check_word(rd, row_src[r], "SRC readback");
    apb_read(npu_pkg::REG_DST, rd);
    check_word(rd, row_dst[r], "DST readback");
    apb_read(npu_pkg::REG_LINES, rd);
    check_word(rd, row_lines[r], "LINES readback");
    req_before = req_seen;
    apb_write(npu_pkg::REG_CTRL, 32'h1);
    if (row_lines[r] != 0) begin
      apb_read(npu_pkg::REG_STATUS, rd);
      check_flag(rd[npu_pkg::STAT_BUSY_BIT], 1'b1, "STATUS busy during transfer");
    end
    do @(negedge xclk); while (!o_interrupt);  // Wait for the done interrupt
    apb_read(npu_pkg::REG_STATUS, rd);
    check_flag(rd[npu_pkg::STAT_BUSY_BIT], 1'b0, "STATUS busy after transfer");
    check_flag(rd[npu_pkg::STAT_DONE_BIT], 1'b1, "STATUS done after transfer");
    check_word(req_seen - req_before, row_lines[r], "requests seen by memory");
    verify_row(r);
    apb_write(npu_pkg::REG_STATUS, 32'h1 << npu_pkg::STAT_DONE_BIT);
    @(negedge xclk);
    check_flag(o_interrupt, 1'b0, "interrupt after done clear");
    apb_read(npu_pkg::REG_STATUS, rd);
    check_flag(rd[npu_pkg::STAT_DONE_BIT], 1'b0, "STATUS done after clear");
  endtask

  function automatic int unsigned total_lines();
    int unsigned sum;
    sum = 0;
    for (int r = 0; r < N_ROWS; r++)
      sum += row_lines[r];
    return sum;
  endfunction

  initial begin
    npu_pkg::word_t rd;
    i_reset   = 1'b1;
    i_paddr   = '0;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_pwdata  = '0;
    repeat (4) @(posedge xclk);
    i_reset <= 1'b0;
    @(negedge xclk);
    check_flag(o_interrupt, 1'b0, "interrupt after reset");
    check_flag(o_mrd_req_valid, 1'b0, "request valid after reset");
    check_flag(o_mrd_rsp_ready, 1'b0, "response ready after reset");
    apb_read(npu_pkg::REG_STATUS, rd);
    check_flag(rd[npu_pkg::STAT_BUSY_BIT], 1'b0, "STATUS busy after reset");
    check_flag(rd[npu_pkg::STAT_DONE_BIT], 1'b0, "STATUS done after reset");
    for (int r = 0; r < N_ROWS; r++)
      run_row(r);
    for (int r = 0; r < N_ROWS; r++)
      verify_row(r);  // Later rows leave earlier words alone
    if (npu_sys_i.u_chk.fail_cnt == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", npu_sys_i.u_chk.fail_cnt);
      $display("TEST FAILED");
      $fatal(1, "Assertion failures");
    end
  end

  initial begin : watchdog
    int unsigned limit;
    limit = total_lines() * 20 + 2000;
    repeat (limit) @(posedge xclk);
    $display("Timeout, the run did not finish within %0d cycles", limit);
    $display("TEST FAILED");
    $fatal(1, "Watchdog timeout");
  end

endmodule

`default_nettype wire

//--- sources.f
src/npu_pkg.sv
src/npu_buffer.sv
src/buffer_port_mux.sv
src/dma_read_engine.sv
src/npu_apb_regs.sv
src/npu_sys.sv
bench/npu_sys_chk.sv
bench/tb_npu_sys.sv

//--- src/buffer_port_mux.sv
/*
  Buffer port mux, steers DMA writes and window reads to the IOB or the WB
*/
`timescale 1ns/100ps
`default_nettype none

module buffer_port_mux #(
  parameter int IOB_DEPTH = 256,
  parameter int WB_DEPTH  = 512
) (
  input  wire                              xclk,
  input  wire                              i_reset,
  input  wire                              i_dma_we,
  input  wire  npu_pkg::addr_t             i_dma_addr,
  input  wire  npu_pkg::word_t             i_dma_wdata,
  input  wire  npu_pkg::addr_t             i_win_addr,
  output npu_pkg::word_t                   o_win_data,
  output logic                             o_iob_en,
  output logic                             o_iob_we,
  output logic [$clog2(IOB_DEPTH)-1:0]     o_iob_addr,
  output npu_pkg::word_t                   o_iob_wdata,
  input  wire  npu_pkg::word_t             i_iob_rdata,
  output logic                             o_wb_en,
  output logic                             o_wb_we,
  output logic [$clog2(WB_DEPTH)-1:0]      o_wb_addr,
  output npu_pkg::word_t                   o_wb_wdata,
  input  wire  npu_pkg::word_t             i_wb_rdata
);

  localparam int IOB_AW = $clog2(IOB_DEPTH);
  localparam int WB_AW  = $clog2(WB_DEPTH);

  logic                          dma_wb;
  logic                          win_wb;
  logic                          win_wb_q;  // Lines up with the read data
  logic                          iob_wr;
  logic                          wb_wr;
  logic [npu_pkg::BUF_IDX_W-1:0] dma_idx;
  logic [npu_pkg::BUF_IDX_W-1:0] win_idx;

  assign dma_wb  = npu_pkg::buf_is_wb(i_dma_addr);
  assign win_wb  = npu_pkg::buf_is_wb(i_win_addr);
  assign dma_idx = npu_pkg::buf_idx(i_dma_addr);
  assign win_idx = npu_pkg::buf_idx(i_win_addr);

  assign iob_wr = i_dma_we && !dma_wb;
  assign wb_wr  = i_dma_we && dma_wb;

  // DMA write has the port, else the window reads the buffer it selects
  assign o_iob_en    = iob_wr || !win_wb;
  assign o_iob_we    = iob_wr;
  assign o_iob_addr  = iob_wr ? dma_idx[IOB_AW-1:0] : win_idx[IOB_AW-1:0];
  assign o_iob_wdata = i_dma_wdata;

  assign o_wb_en    = wb_wr || win_wb;
  assign o_wb_we    = wb_wr;
  assign o_wb_addr  = wb_wr ? dma_idx[WB_AW-1:0] : win_idx[WB_AW-1:0];
  assign o_wb_wdata = i_dma_wdata;

  always_ff @(posedge xclk) begin
    if (i_reset)
      win_wb_q <= 1'b0;
    else
      win_wb_q <= win_wb;
  end

  assign o_win_data = win_wb_q ? i_wb_rdata : i_iob_rdata;

endmodule

`default_nettype wire

//--- src/dma_read_engine.sv
/*
  DMA read engine
  Streams LINES words from external memory into the on-chip buffers, several in flight
*/
`timescale 1ns/100ps
`default_nettype none

module dma_read_engine #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  wire                     xclk,
  input  wire                     i_reset,
  // Descriptor
  input  wire                     i_start,
  input  wire  npu_pkg::addr_t    i_src,
  input  wire  npu_pkg::addr_t    i_dst,
  input  wire  npu_pkg::addr_t    i_lines,
  output logic                    o_busy,
  output logic                    o_done,
  // Memory request channel
  output logic                    o_mrd_req_valid,
  output npu_pkg::addr_t          o_mrd_req_addr,
  input  wire                     i_mrd_req_ready,
  // Memory response channel, in request order
  input  wire                     i_mrd_rsp_valid,
  input  wire  npu_pkg::word_t    i_mrd_rsp_data,
  output logic                    o_mrd_rsp_ready,
  // Buffer write port
  output logic                    o_buf_we,
  output npu_pkg::addr_t          o_buf_addr,
  output npu_pkg::word_t          o_buf_wdata
);

  localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);

  logic             busy_q;
  logic             load;
  logic             req_fire;
  logic             rsp_fire;
  logic             last_rsp;
  npu_pkg::addr_t   lines_q;
  npu_pkg::addr_t   req_addr_q;  // Next external byte address
  npu_pkg::addr_t   wr_addr_q;   // Next buffer word address
  npu_pkg::addr_t   req_cnt_q;   // Requests accepted
  npu_pkg::addr_t   rcv_cnt_q;   // Words received
  logic [OUT_W-1:0] out_cnt_q;   // Requests owed a response

  assign load     = i_start && !busy_q;
  assign req_fire = o_mrd_req_valid && i_mrd_req_ready;
  assign rsp_fire = i_mrd_rsp_valid && o_mrd_rsp_ready;
  assign last_rsp = rsp_fire && (rcv_cnt_q + 1'b1 == lines_q);

  // Valid only drops on a handshake, so a stalled request holds
  assign o_mrd_req_valid = busy_q && (req_cnt_q != lines_q) &&
                           (out_cnt_q < OUT_W'(MAX_OUTSTANDING));
  assign o_mrd_req_addr  = req_addr_q;
  assign o_mrd_rsp_ready = busy_q && (out_cnt_q != '0);

  assign o_busy = busy_q;
  assign o_done = busy_q && ((lines_q == '0) || last_rsp);  // Zero lines ends a cycle later

  // Each accepted response lands in the buffer in the same cycle
  assign o_buf_we    = rsp_fire;
  assign o_buf_addr  = wr_addr_q;
  assign o_buf_wdata = i_mrd_rsp_data;

  always_ff @(posedge xclk) begin
    if (i_reset) begin
      busy_q    <= 1'b0;
      req_cnt_q <= '0;
      rcv_cnt_q <= '0;
      out_cnt_q <= '0;
    end else if (load) begin
      busy_q    <= 1'b1;
      req_cnt_q <= '0;
      rcv_cnt_q <= '0;
      out_cnt_q <= '0;
    end else if (busy_q) begin
      if (o_done)
        busy_q <= 1'b0;
      if (req_fire)
        req_cnt_q <= req_cnt_q + 1'b1;
      if (rsp_fire)
        rcv_cnt_q <= rcv_cnt_q + 1'b1;
      out_cnt_q <= out_cnt_q + OUT_W'(req_fire) - OUT_W'(rsp_fire);
    end
  end

  // Address pointers
  always_ff @(posedge xclk) begin
    if (load) begin
      lines_q    <= i_lines;
      req_addr_q <= i_src;
      wr_addr_q  <= i_dst;
    end else begin
      if (req_fire)
        req_addr_q <= req_addr_q + 32'd4;  // One word per request
      if (rsp_fire)
        wr_addr_q <= wr_addr_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/npu_apb_regs.sv
/*
  APB register file for the NPU loader
  Holds the DMA descriptor, status, sticky done interrupt and buffer readback window
*/
`timescale 1ns/100ps
`default_nettype none

module npu_apb_regs (
  input  wire                                xclk,
  input  wire                                i_reset,
  // APB slave, no wait states
  input  wire  [npu_pkg::PADDR_W-1:0]        i_paddr,
  input  wire                                i_psel,
  input  wire                                i_penable,
  input  wire                                i_pwrite,
  input  wire  npu_pkg::word_t               i_pwdata,
  output npu_pkg::word_t                     o_prdata,
  // Descriptor to the DMA
  output logic                               o_start,
  output npu_pkg::addr_t                     o_src,
  output npu_pkg::addr_t                     o_dst,
  output npu_pkg::addr_t                     o_lines,
  input  wire                                i_busy,
  input  wire                                i_done,
  // Buffer readback window
  output npu_pkg::addr_t                     o_win_addr,
  input  wire  npu_pkg::word_t               i_win_data,
  output logic                               o_interrupt
);

  logic           wr_en;
  npu_pkg::addr_t src_q;
  npu_pkg::addr_t dst_q;
  npu_pkg::addr_t lines_q;
  npu_pkg::addr_t win_q;
  logic           done_q;  // Sticky until cleared by the host

  assign wr_en = i_psel && i_penable && i_pwrite;  // Access phase write

  // Start is ignored while a transfer runs
  assign o_start = wr_en && (i_paddr == npu_pkg::REG_CTRL) && i_pwdata[0] && !i_busy;

  always_ff @(posedge xclk) begin
    if (i_reset) begin
      src_q   <= '0;
      dst_q   <= '0;
      lines_q <= '0;
      win_q   <= '0;
    end else if (wr_en) begin
      case (i_paddr)
        npu_pkg::REG_SRC:   src_q   <= i_pwdata;
        npu_pkg::REG_DST:   dst_q   <= i_pwdata;
        npu_pkg::REG_LINES: lines_q <= i_pwdata;
        npu_pkg::REG_WIN:   win_q   <= i_pwdata;
        default: ;
      endcase
    end
  end

  // Done flag, a new completion wins over a clear in the same cycle
  always_ff @(posedge xclk) begin
    if (i_reset) begin
      done_q <= 1'b0;
    end else if (i_done) begin
      done_q <= 1'b1;
    end else if (wr_en && (i_paddr == npu_pkg::REG_STATUS) &&
                 i_pwdata[npu_pkg::STAT_DONE_BIT]) begin
      done_q <= 1'b0;
    end
  end

  always_comb begin
    o_prdata = '0;  // CTRL and unmapped offsets read as zero
    case (i_paddr)
      npu_pkg::REG_SRC:   o_prdata = src_q;
      npu_pkg::REG_DST:   o_prdata = dst_q;
      npu_pkg::REG_LINES: o_prdata = lines_q;
      npu_pkg::REG_STATUS: begin
        o_prdata[npu_pkg::STAT_BUSY_BIT] = i_busy;
        o_prdata[npu_pkg::STAT_DONE_BIT] = done_q;
      end
      npu_pkg::REG_WIN:   o_prdata = win_q;
      npu_pkg::REG_WDATA: o_prdata = i_win_data;  // Fetched during setup phase
      default: ;
    endcase
  end

  assign o_src       = src_q;
  assign o_dst       = dst_q;
  assign o_lines     = lines_q;
  assign o_win_addr  = win_q;
  assign o_interrupt = done_q;

endmodule

`default_nettype wire

//--- src/npu_buffer.sv
/*
  Single-port synchronous buffer, registered read data
*/
`timescale 1ns/100ps
`default_nettype none

module npu_buffer #(
  parameter int DEPTH = 256
) (
  input  wire                          xclk,
  input  wire                          i_en,
  input  wire                          i_we,
  input  wire  [$clog2(DEPTH)-1:0]     i_addr,
  input  wire  npu_pkg::word_t         i_wdata,
  output npu_pkg::word_t               o_rdata
);

  npu_pkg::word_t mem [DEPTH];

  always_ff @(posedge xclk) begin
    if (i_en) begin
      if (i_we)
        mem[i_addr] <= i_wdata;
      o_rdata <= mem[i_addr];  // Old data on a write cycle
    end
  end

endmodule

`default_nettype wire

//--- src/npu_pkg.sv
/*
  NPU data-loading subsystem shared definitions
  Widths, word types, APB register map and buffer select rule
*/
`default_nettype none

package npu_pkg;

  localparam int ADDR_W  = 32;  // External byte address and descriptor fields
  localparam int WORD_W  = 32;
  localparam int PADDR_W = 8;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // APB register map
  localparam logic [PADDR_W-1:0] REG_CTRL   = 8'h00;  // Bit 0 starts the DMA
  localparam logic [PADDR_W-1:0] REG_SRC    = 8'h04;
  localparam logic [PADDR_W-1:0] REG_DST    = 8'h08;
  localparam logic [PADDR_W-1:0] REG_LINES  = 8'h0C;
  localparam logic [PADDR_W-1:0] REG_STATUS = 8'h10;
  localparam logic [PADDR_W-1:0] REG_WIN    = 8'h14;  // Readback window word address
  localparam logic [PADDR_W-1:0] REG_WDATA  = 8'h18;  // Buffer word at the window

  // Buffer select inside a word address
  localparam int BUF_SEL_BIT = 12;  // 1 selects WB, 0 selects IOB
  localparam int BUF_IDX_W   = 12;

  localparam int STAT_BUSY_BIT = 0;
  localparam int STAT_DONE_BIT = 1;

  // True when the word address targets the weight buffer
  function automatic logic buf_is_wb(addr_t addr);
    return addr[BUF_SEL_BIT];
  endfunction

  // Word index below the select bit
  function automatic logic [BUF_IDX_W-1:0] buf_idx(addr_t addr);
    return addr[BUF_IDX_W-1:0];
  endfunction

endpackage

`default_nettype wire

//--- src/npu_sys.sv
/*
  NPU system shell, data-loading subsystem
  APB registers, DMA read engine, buffer port mux, IOB and WB
*/
`timescale 1ns/100ps
`default_nettype none

module npu_sys #(
  parameter int IOB_DEPTH       = 256,
  parameter int WB_DEPTH        = 512,
  parameter int MAX_OUTSTANDING = 4
) (
  input  wire                                xclk,
  input  wire                                i_reset,
  // APB host port
  input  wire  [npu_pkg::PADDR_W-1:0]        i_paddr,
  input  wire                                i_psel,
  input  wire                                i_penable,
  input  wire                                i_pwrite,
  input  wire  npu_pkg::word_t               i_pwdata,
  output npu_pkg::word_t                     o_prdata,
  // External memory read channels
  output logic                               o_mrd_req_valid,
  output npu_pkg::addr_t                     o_mrd_req_addr,
  input  wire                                i_mrd_req_ready,
  input  wire                                i_mrd_rsp_valid,
  input  wire  npu_pkg::word_t               i_mrd_rsp_data,
  output logic                               o_mrd_rsp_ready,
  output logic                               o_interrupt
);

  // Descriptor and status
  logic           start;
  logic           busy;
  logic           done;
  npu_pkg::addr_t src;
  npu_pkg::addr_t dst;
  npu_pkg::addr_t lines;
  // DMA write and window read
  logic           dma_we;
  npu_pkg::addr_t dma_addr;
  npu_pkg::word_t dma_wdata;
  npu_pkg::addr_t win_addr;
  npu_pkg::word_t win_data;
  // Buffer ports
  logic                         iob_en;
  logic                         iob_we;
  logic [$clog2(IOB_DEPTH)-1:0] iob_addr;
  npu_pkg::word_t               iob_wdata;
  npu_pkg::word_t               iob_rdata;
  logic                         wb_en;
  logic                         wb_we;
  logic [$clog2(WB_DEPTH)-1:0]  wb_addr;
  npu_pkg::word_t               wb_wdata;
  npu_pkg::word_t               wb_rdata;

  npu_apb_regs u_regs (
    .xclk        (xclk),
    .i_reset     (i_reset),
    .i_paddr     (i_paddr),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_start     (start),
    .o_src       (src),
    .o_dst       (dst),
    .o_lines     (lines),
    .i_busy      (busy),
    .i_done      (done),
    .o_win_addr  (win_addr),
    .i_win_data  (win_data),
    .o_interrupt (o_interrupt)
  );

  dma_read_engine #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_dma (
    .xclk            (xclk),
    .i_reset         (i_reset),
    .i_start         (start),
    .i_src           (src),
    .i_dst           (dst),
    .i_lines         (lines),
    .o_busy          (busy),
    .o_done          (done),
    .o_mrd_req_valid (o_mrd_req_valid),
    .o_mrd_req_addr  (o_mrd_req_addr),
    .i_mrd_req_ready (i_mrd_req_ready),
    .i_mrd_rsp_valid (i_mrd_rsp_valid),
    .i_mrd_rsp_data  (i_mrd_rsp_data),
    .o_mrd_rsp_ready (o_mrd_rsp_ready),
    .o_buf_we        (dma_we),
    .o_buf_addr      (dma_addr),
    .o_buf_wdata     (dma_wdata)
  );

  buffer_port_mux #(
    .IOB_DEPTH (IOB_DEPTH),
    .WB_DEPTH  (WB_DEPTH)
  ) u_mux (
    .xclk        (xclk),
    .i_reset     (i_reset),
    .i_dma_we    (dma_we),
    .i_dma_addr  (dma_addr),
    .i_dma_wdata (dma_wdata),
    .i_win_addr  (win_addr),
    .o_win_data  (win_data),
    .o_iob_en    (iob_en),
    .o_iob_we    (iob_we),
    .o_iob_addr  (iob_addr),
    .o_iob_wdata (iob_wdata),
    .i_iob_rdata (iob_rdata),
    .o_wb_en     (wb_en),
    .o_wb_we     (wb_we),
    .o_wb_addr   (wb_addr),
    .o_wb_wdata  (wb_wdata),
    .i_wb_rdata  (wb_rdata)
  );

  npu_buffer #(.DEPTH(IOB_DEPTH)) u_iob (
    .xclk    (xclk),
    .i_en    (iob_en),
    .i_we    (iob_we),
    .i_addr  (iob_addr),
    .i_wdata (iob_wdata),
    .o_rdata (iob_rdata)
  );

  npu_buffer #(.DEPTH(WB_DEPTH)) u_wb (
    .xclk    (xclk),
    .i_en    (wb_en),
    .i_we    (wb_we),
    .i_addr  (wb_addr),
    .i_wdata (wb_wdata),
    .o_rdata (wb_rdata)
  );

endmodule

`default_nettype wire
